//--- hdl/edge_pkg.sv
package edge_pkg;

	// Compute-unit id, returned unchanged with the edge word
	typedef logic [7:0] cu_id_t;

	localparam int weight_bits = 16;

	// Request-to-result latency of the read path, in clock cycles
	localparam int read_latency = 7;

	// Edge request from a client
	// Index width kept numeric so this package stands alone
	typedef struct packed {
		logic                   valid;
		logic [5:0]             word_index;
		cu_id_t                 cu_id;
		logic [weight_bits-1:0] weight;
	} edge_req_t;

	typedef struct packed {
		cu_id_t                 cu_id;
		logic [weight_bits-1:0] weight;
		logic [31:0]            data;
	} edge_data_payload_t;

	// Edge result, the byte-reversed word plus its tags
	typedef struct packed {
		logic               valid;
		edge_data_payload_t payload;
	} edge_data_t;

endpackage

//--- hdl/mem_pkg.sv
package mem_pkg;

	// Line memory geometry
	localparam int line_bits       = 128;
	localparam int half_bits       = line_bits / 2;
	localparam int word_bits       = 32;
	localparam int words_per_half  = half_bits / word_bits;
	localparam int words_per_line  = line_bits / word_bits;
	localparam int line_count      = 16;
	localparam int line_addr_bits  = $clog2(line_count);
	localparam int offset_bits     = $clog2(words_per_line);
	localparam int word_index_bits = line_addr_bits + offset_bits;

	typedef struct packed {
		logic [line_addr_bits-1:0]        line_addr;
		logic [offset_bits-1:0]           offset;
		edge_pkg::cu_id_t                 cu_id;
		logic [edge_pkg::weight_bits-1:0] weight;
	} read_cmd_payload_t;

	// Line read command
	typedef struct packed {
		logic              valid;
		read_cmd_payload_t payload;
	} read_cmd_t;

	typedef struct packed {
		read_cmd_payload_t      cmd;
		logic [half_bits-1:0]   data;
	} read_half_payload_t;

	// One half of a line, tagged with its own copy of the command
	typedef struct packed {
		logic               valid;
		read_half_payload_t payload;
	} read_half_t;

	// Single-word write into the line memory
	typedef struct packed {
		logic                       valid;
		logic [word_index_bits-1:0] word_index;
		logic [word_bits-1:0]       data;
	} mem_write_t;

endpackage

//--- hdl/valid_pipe.sv
`timescale 1ns/100ps

module valid_pipe #(
	parameter type payload_t = logic [7:0],
	parameter int  depth     = 1
) (
	input  logic     clock,
	input  logic     rstn,
	input  logic     in_valid,
	input  payload_t in_payload,
	output logic     out_valid,
	output payload_t out_payload
);

	logic [depth-1:0] valid_q;
	payload_t         payload_q [depth];

	// Valid chain, cleared by reset
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			valid_q <= '0;
		end else begin
			valid_q[0] <= in_valid;
			for (int i = 1; i < depth; i++) begin
				valid_q[i] <= valid_q[i-1];
			end
		end
	end

	// Payload follows its valid bit stage by stage
	always_ff @(posedge clock) begin
		payload_q[0] <= in_payload;
		for (int i = 1; i < depth; i++) begin
			payload_q[i] <= payload_q[i-1];
		end
	end

	assign out_valid   = valid_q[depth-1];
	assign out_payload = payload_q[depth-1];

endmodule

//--- hdl/edge_read_request.sv
`timescale 1ns/100ps

module edge_read_request (
	input  logic                clock,
	input  logic                rstn,
	input  logic                enable,
	input  edge_pkg::edge_req_t req,
	output mem_pkg::read_cmd_t  rd_cmd
);

	import mem_pkg::*;

	logic              req_accept;
	read_cmd_payload_t cmd_in;
	logic              cmd_valid;
	read_cmd_payload_t cmd_payload;

	// Requests seen while disabled are dropped here
	assign req_accept = req.valid && enable;

	// Word index splits into line address and word offset
	always_comb begin
		cmd_in.line_addr = req.word_index[word_index_bits-1 -: line_addr_bits];
		cmd_in.offset    = req.word_index[offset_bits-1:0];
		cmd_in.cu_id     = req.cu_id;
		cmd_in.weight    = req.weight;
	end

	//////////////////////////////////////////////////////////////////////
	// Command register
	//////////////////////////////////////////////////////////////////////

	valid_pipe #(
		.payload_t (read_cmd_payload_t),
		.depth     (1)
	) u_cmd_reg (
		.clock       (clock),
		.rstn        (rstn),
		.in_valid    (req_accept),
		.in_payload  (cmd_in),
		.out_valid   (cmd_valid),
		.out_payload (cmd_payload)
	);

	assign rd_cmd = '{valid: cmd_valid, payload: cmd_payload};

endmodule

//--- hdl/edge_line_memory.sv
`timescale 1ns/100ps

module edge_line_memory (
	input  logic                clock,
	input  logic                rstn,
	input  mem_pkg::mem_write_t mem_wr,
	input  mem_pkg::read_cmd_t  rd_cmd,
	output mem_pkg::read_half_t half_0,
	output mem_pkg::read_half_t half_1
);

	import mem_pkg::*;

	// Storage, one packed line per entry, word 0 in the low bits
	logic [words_per_line-1:0][word_bits-1:0] mem [line_count];

	logic [line_addr_bits-1:0] wr_line;
	logic [offset_bits-1:0]    wr_word;

	// Read stage
	logic                 rd_valid_q;
	read_cmd_payload_t    rd_cmd_q;
	logic [line_bits-1:0] line_q;

	// Upper half waits one more cycle
	logic                 hi_valid_q;
	read_cmd_payload_t    hi_cmd_q;
	logic [half_bits-1:0] hi_data_q;

	//////////////////////////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////////////////////////

	assign wr_line = mem_wr.word_index[word_index_bits-1 -: line_addr_bits];
	assign wr_word = mem_wr.word_index[offset_bits-1:0];

	always_ff @(posedge clock) begin
		if (mem_wr.valid) begin
			mem[wr_line][wr_word] <= mem_wr.data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read port
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rd_valid_q <= 1'b0;
			hi_valid_q <= 1'b0;
		end else begin
			rd_valid_q <= rd_cmd.valid;
			hi_valid_q <= rd_valid_q;
		end
	end

	always_ff @(posedge clock) begin
		rd_cmd_q  <= rd_cmd.payload;
		line_q    <= mem[rd_cmd.payload.line_addr];
		hi_cmd_q  <= rd_cmd_q;
		hi_data_q <= line_q[line_bits-1:half_bits];
	end

	// Lower half straight from the read register, words 0 and 1
	assign half_0 = '{
		valid:   rd_valid_q,
		payload: '{cmd: rd_cmd_q, data: line_q[half_bits-1:0]}
	};

	// Upper half one cycle behind, words 2 and 3
	assign half_1 = '{
		valid:   hi_valid_q,
		payload: '{cmd: hi_cmd_q, data: hi_data_q}
	};

endmodule

//--- hdl/edge_data_extract.sv
`timescale 1ns/100ps

module edge_data_extract (
	input  logic                 clock,
	input  logic                 rstn,
	input  mem_pkg::read_half_t  half_0,
	input  mem_pkg::read_half_t  half_1,
	output edge_pkg::edge_data_t edge_data
);

	import mem_pkg::*;
	import edge_pkg::*;

	// Halves after realignment
	logic               h0_valid;
	read_half_payload_t h0_payload;
	logic               h1_valid;
	read_half_payload_t h1_payload;
	logic               both_valid;

	// Word pair stage
	logic                   pair_valid;
	logic [offset_bits-1:0] pair_offset;
	cu_id_t                 pair_cu_id;
	logic [weight_bits-1:0] pair_weight;
	logic [half_bits-1:0]   pair_data;

	// Selected word stage
	logic                   word_valid;
	cu_id_t                 word_cu_id;
	logic [weight_bits-1:0] word_weight;
	logic [word_bits-1:0]   word_data;

	// Output register
	logic               out_valid;
	edge_data_payload_t out_payload;

	// Reverse the byte order of one word
	function automatic logic [word_bits-1:0] swap_bytes(input logic [word_bits-1:0] word);
		logic [word_bits-1:0] swapped;
		for (int b = 0; b < word_bits / 8; b++) begin
			swapped[8*b +: 8] = word[word_bits - 8*(b+1) +: 8];
		end
		return swapped;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Realign halves
	//////////////////////////////////////////////////////////////////////

	// half_0 leaves the memory one cycle early, so it gets the extra stage
	valid_pipe #(
		.payload_t (read_half_payload_t),
		.depth     (2)
	) u_half_0_align (
		.clock       (clock),
		.rstn        (rstn),
		.in_valid    (half_0.valid),
		.in_payload  (half_0.payload),
		.out_valid   (h0_valid),
		.out_payload (h0_payload)
	);

	valid_pipe #(
		.payload_t (read_half_payload_t),
		.depth     (1)
	) u_half_1_align (
		.clock       (clock),
		.rstn        (rstn),
		.in_valid    (half_1.valid),
		.in_payload  (half_1.payload),
		.out_valid   (h1_valid),
		.out_payload (h1_payload)
	);

	assign both_valid = h0_valid && h1_valid;

	//////////////////////////////////////////////////////////////////////
	// Select, extract and swap
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pair_valid <= 1'b0;
			word_valid <= 1'b0;
			out_valid  <= 1'b0;
		end else begin
			pair_valid <= both_valid;
			word_valid <= pair_valid;
			out_valid  <= word_valid;
		end
	end

	// Keep the half that holds the addressed word, tags from that half
	always_ff @(posedge clock) begin
		if (both_valid) begin
			pair_offset <= h0_payload.cmd.offset;
			if (h0_payload.cmd.offset >= words_per_half) begin
				pair_cu_id  <= h1_payload.cmd.cu_id;
				pair_weight <= h1_payload.cmd.weight;
				pair_data   <= h1_payload.data;
			end else begin
				pair_cu_id  <= h0_payload.cmd.cu_id;
				pair_weight <= h0_payload.cmd.weight;
				pair_data   <= h0_payload.data;
			end
		end
	end

	// Lower 32 bits hold the even word of a half
	always_ff @(posedge clock) begin
		word_cu_id  <= pair_cu_id;
		word_weight <= pair_weight;
		word_data   <= pair_data[(pair_offset % words_per_half) * word_bits +: word_bits];
	end

	// Swap folded into the output register
	always_ff @(posedge clock) begin
		out_payload.cu_id  <= word_cu_id;
		out_payload.weight <= word_weight;
		out_payload.data   <= swap_bytes(word_data);
	end

	assign edge_data = '{valid: out_valid, payload: out_payload};

endmodule

//--- hdl/edge_read_top.sv
`timescale 1ns/100ps

module edge_read_top (
	input  logic                 clock,
	input  logic                 rstn,
	input  logic                 enable,
	input  edge_pkg::edge_req_t  req,
	input  mem_pkg::mem_write_t  mem_wr,
	output edge_pkg::edge_data_t edge_data
);

	import mem_pkg::*;

	read_cmd_t  rd_cmd;
	read_half_t half_0;
	read_half_t half_1;

	//////////////////////////////////////////////////////////////////////
	// Read path
	//////////////////////////////////////////////////////////////////////

	// Index to line address and offset
	edge_read_request u_request (
		.clock  (clock),
		.rstn   (rstn),
		.enable (enable),
		.req    (req),
		.rd_cmd (rd_cmd)
	);

	edge_line_memory u_memory (
		.clock  (clock),
		.rstn   (rstn),
		.mem_wr (mem_wr),
		.rd_cmd (rd_cmd),
		.half_0 (half_0),
		.half_1 (half_1)
	);

	// Halves back to one tagged word
	edge_data_extract u_extract (
		.clock     (clock),
		.rstn      (rstn),
		.half_0    (half_0),
		.half_1    (half_1),
		.edge_data (edge_data)
	);

endmodule

//--- tests/edge_read_props.sv
`timescale 1ns/100ps

module edge_read_props (
	input logic                 clock,
	input logic                 rstn,
	input logic                 enable,
	input edge_pkg::edge_req_t  req,
	input mem_pkg::read_cmd_t   rd_cmd,
	input edge_pkg::edge_data_t edge_data
);

	import edge_pkg::*;

	logic                    accept;
	logic [read_latency-1:0] accept_hist;
	int unsigned             error_count = 0;

	assign accept = req.valid && enable;

	// History of accepted requests, one bit per cycle
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			accept_hist <= '0;
		end else begin
			accept_hist <= {accept_hist[read_latency-2:0], accept};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Reset behavior
	//////////////////////////////////////////////////////////////////////

	reset_quiet: assert property (@(posedge clock)
		(!rstn || $rose(rstn)) |-> (!edge_data.valid && !rd_cmd.valid))
		else begin
			error_count++;
			$error("Valid output high during or right after reset");
		end

	//////////////////////////////////////////////////////////////////////
	// Valid timing and payload
	//////////////////////////////////////////////////////////////////////

	cmd_timing: assert property (@(posedge clock) disable iff (!rstn)
		rd_cmd.valid == accept_hist[0])
		else begin
			error_count++;
			$error("rd_cmd valid does not follow the accepted request");
		end

	result_timing: assert property (@(posedge clock) disable iff (!rstn)
		edge_data.valid == accept_hist[read_latency-1])
		else begin
			error_count++;
			$error("edge_data valid does not match the request latency");
		end

	payload_known: assert property (@(posedge clock) disable iff (!rstn)
		edge_data.valid |-> !$isunknown(edge_data.payload))
		else begin
			error_count++;
			$error("edge_data payload has unknown bits while valid");
		end

endmodule

bind edge_read_top edge_read_props u_props (
	.clock     (clock),
	.rstn      (rstn),
	.enable    (enable),
	.req       (req),
	.rd_cmd    (rd_cmd),
	.edge_data (edge_data)
);

//--- tests/edge_read_tb.sv
`timescale 1ns/100ps

module edge_read_tb;

	import edge_pkg::*;
	import mem_pkg::*;

	localparam int clock_half   = 20;
	localparam int random_count = 200;
	// Stimulus stays under 1000 cycles, limit is twice that
	localparam int cycle_limit  = 2000;

	typedef struct packed {
		logic [31:0] data;
		cu_id_t      cu_id;
		logic [15:0] weight;
		int          cycle;
	} expect_t;

	logic       clock;
	logic       rstn;
	logic       enable;
	edge_req_t  req;
	mem_write_t mem_wr;
	edge_data_t edge_data;

	logic [31:0] model [64];
	expect_t     expect_q [$];
	int          seed         = 32'h48c7_43d5;
	int          cycle_count  = 0;
	int          accept_count = 0;
	int          result_count = 0;

	edge_read_top uut (
		.clock     (clock),
		.rstn      (rstn),
		.enable    (enable),
		.req       (req),
		.mem_wr    (mem_wr),
		.edge_data (edge_data)
	);

	initial begin
		clock = 1'b0;
		forever #clock_half clock = ~clock;
	end

	// Byte 0 moves to the top, byte 3 to the bottom
	function automatic logic [31:0] byte_reversed(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	task automatic fail_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic fail_event(input string what);
		$display("At %0t: %s", $time, what);
		$display("Done: errors found");
		$fatal(1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus, one cycle per call, driven on the falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic drive(input logic en, input logic rv, input logic [5:0] idx,
		input cu_id_t id, input logic [15:0] w, input logic wv,
		input logic [5:0] widx, input logic [31:0] wdata);
		@(negedge clock);
		enable = en;
		req    = '{valid: rv, word_index: idx, cu_id: id, weight: w};
		mem_wr = '{valid: wv, word_index: widx, data: wdata};
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) drive(1'b1, 1'b0, '0, '0, '0, 1'b0, '0, '0);
	endtask

	task automatic write_word(input logic [5:0] idx, input logic [31:0] data);
		drive(1'b1, 1'b0, '0, '0, '0, 1'b1, idx, data);
	endtask

	task automatic read_word(input logic [5:0] idx, input cu_id_t id, input logic [15:0] w);
		drive(1'b1, 1'b1, idx, id, w, 1'b0, '0, '0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model and result checks
	//////////////////////////////////////////////////////////////////////

	always @(posedge clock) begin : monitor
		expect_t item;
		if (mem_wr.valid) begin
			model[mem_wr.word_index] = mem_wr.data;
		end
		if (rstn && edge_data.valid) begin
			assert (expect_q.size() > 0)
				else fail_event("Result appeared with no request outstanding");
			item = expect_q.pop_front();
			result_count++;
			assert (edge_data.payload.data == item.data)
				else fail_value("edge_data.payload.data", item.data, edge_data.payload.data);
			assert (edge_data.payload.cu_id == item.cu_id)
				else fail_value("edge_data.payload.cu_id", item.cu_id, edge_data.payload.cu_id);
			assert (edge_data.payload.weight == item.weight)
				else fail_value("edge_data.payload.weight", item.weight,
					edge_data.payload.weight);
			assert (cycle_count == item.cycle + read_latency)
				else fail_value("result cycle", item.cycle + read_latency, cycle_count);
		end
		// Write of this edge is already in the model
		if (rstn && req.valid && enable) begin
			expect_q.push_back(expect_t'{data: byte_reversed(model[req.word_index]),
				cu_id: req.cu_id, weight: req.weight, cycle: cycle_count});
			accept_count++;
		end
		cycle_count++;
	end

	always @(negedge clock) begin
		if (uut.u_props.error_count != 0) begin
			fail_event("A bound property of the read path failed");
		end
	end

	initial begin : watchdog
		while (cycle_count < cycle_limit) begin
			@(posedge clock);
		end
		$display("Run timed out after %0d cycles", cycle_limit);
		$display("Done: errors found");
		$fatal(1);
	end

	initial begin : stimulus
		logic [31:0] rnd;
		logic [5:0]  idx;
		rstn   = 1'b0;
		enable = 1'b0;
		req    = '0;
		mem_wr = '0;
		repeat (2) @(negedge clock);
		rstn = 1'b1;

		// Quiet pipeline after reset
		idle_cycles(20);

		// Fill every word, then sweep all indices
		for (int i = 0; i < 64; i++) begin
			write_word(6'(i), $random(seed));
		end
		for (int i = 0; i < 64; i++) begin
			read_word(6'(i), 8'(i + 64), 16'(i * 3 + 1));
		end
		idle_cycles(10);

		// Back-to-back random reads with random tags
		for (int i = 0; i < random_count; i++) begin
			rnd = $random(seed);
			read_word(rnd[5:0], rnd[13:6], rnd[31:16]);
		end
		idle_cycles(10);

		// Enable toggles while requests keep coming
		for (int i = 0; i < 100; i++) begin
			rnd = $random(seed);
			drive(rnd[0], 1'b1, rnd[6:1], rnd[14:7], rnd[31:16], 1'b0, '0, '0);
		end
		idle_cycles(10);

		// Rewrite beside a read of another word, then read it back
		for (int i = 0; i < 32; i++) begin
			rnd = $random(seed);
			idx = rnd[5:0];
			drive(1'b1, 1'b1, idx ^ 6'h15, rnd[13:6], rnd[31:16], 1'b1, idx, $random(seed));
			read_word(idx, rnd[21:14], rnd[15:0]);
		end

		// Every result is due within the fixed latency
		idle_cycles(read_latency + 3);

		if (expect_q.size() == 0 && accept_count == result_count) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("Fail at %0t: result count expected %0d, got %0d", $time,
				accept_count, result_count);
			$display("Done: errors found");
			$fatal(1);
		end
	end

endmodule

//--- files.f
hdl/edge_pkg.sv
hdl/mem_pkg.sv
hdl/valid_pipe.sv
hdl/edge_read_request.sv
hdl/edge_line_memory.sv
hdl/edge_data_extract.sv
hdl/edge_read_top.sv
tests/edge_read_props.sv
tests/edge_read_tb.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = edge_read_tb
FILE_LIST = files.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Done: errors found
PASS_MSG  = Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "TEST FAILED, run ended early"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
